//--- src/qraccGeomPkg.sv
// Array geometry constants for the compute-in-memory column block
// Vector types for wordlines, stored rows, thermometer codes and ADC codes
package qraccGeomPkg;

    // Bit-cell array size
    localparam int numRows = 128;
    localparam int numCols = 8;

    // Column ADC resolution, one thermometer level per code step
    localparam int numAdcBits = 4;
    localparam int numLevels = 2 ** numAdcBits;

    // One bit per row, used for wordlines and MAC input drive
    typedef logic [numRows-1:0] rowVecT;

    // Row index
    typedef logic [$clog2(numRows)-1:0] rowAddrT;

    // One stored row, also write data and sense-amp data
    typedef logic [numCols-1:0] colWordT;

    // All column thermometer codes, column j in bits 16j+15 down to 16j
    typedef logic [numLevels*numCols-1:0] thermT;

    // Decoded column value from 0 to 16, one extra bit for the saturated count
    typedef logic [numAdcBits:0] adcCodeT;

    // All decoded columns, column j in bits 5j+4 down to 5j
    typedef logic [(numAdcBits+1)*numCols-1:0] macCodesT;

endpackage

//--- src/qraccCtrlPkg.sv
// Command operation encoding and sequencer state encoding
package qraccCtrlPkg;

    // Command operations accepted on the command port
    typedef enum logic [1:0] {
        opWrite = 2'd0,
        opRead  = 2'd1,
        opMac   = 2'd2
    } opT;

    // Sequencer states
    // sAccess is the single strobe cycle of a write or read
    // sEval holds the MAC input drive while the columns settle
    typedef enum logic [1:0] {
        sIdle   = 2'd0,
        sAccess = 2'd1,
        sEval   = 2'd2,
        sDone   = 2'd3
    } ctrlStateT;

endpackage

//--- src/qraccArray.sv
// Bit-cell array model with wordline write and unregistered sense-amp read
// Per-column MAC count with a thermometer column ADC
module qraccArray (
    input  logic                  CLK,
    input  qraccGeomPkg::rowVecT  WL,
    input  logic                  PCH,
    input  logic                  WRITE,
    input  qraccGeomPkg::colWordT WR_DATA,
    input  logic                  SAEN,
    input  qraccGeomPkg::rowVecT  VDR_SEL,
    output qraccGeomPkg::colWordT SA_OUT,
    output qraccGeomPkg::thermT   ADC_OUT
);
    import qraccGeomPkg::*;

    // Wide enough for a full column count of 0 to 128
    typedef logic [$clog2(numRows):0] colCountT;

    colWordT mem [numRows];

    // Write every row whose wordline is up
    always_ff @(posedge CLK) begin
        if (PCH && WRITE) begin
            for (int i = 0; i < numRows; i++) begin
                if (WL[i]) begin
                    mem[i] <= WR_DATA;
                end
            end
        end
    end

    // Sense amps see the selected rows on the precharged bitlines
    // Several raised wordlines would pull the same bitlines, modelled as an OR
    always_comb begin
        SA_OUT = '0;
        if (PCH && SAEN) begin
            for (int i = 0; i < numRows; i++) begin
                if (WL[i]) begin
                    SA_OUT = SA_OUT | mem[i];
                end
            end
        end
    end

    // One MAC bitline and one ADC per column
    for (genvar j = 0; j < numCols; j++) begin : genCol
        colCountT colCount;

        // Rows where the drive bit and the stored bit are both 1
        always_comb begin
            colCount = '0;
            for (int i = 0; i < numRows; i++) begin
                colCount = colCount + colCountT'(VDR_SEL[i] & mem[i][j]);
            end
        end

        // Comparator ladder, level k trips once the count exceeds k
        for (genvar k = 0; k < numLevels; k++) begin : genLevel
            assign ADC_OUT[j*numLevels + k] = (colCount > colCountT'(k));
        end
    end

endmodule

//--- src/thermDecoder.sv
// Thermometer to binary conversion for all column ADC outputs
module thermDecoder (
    input  qraccGeomPkg::thermT    therm,
    output qraccGeomPkg::macCodesT codes
);
    import qraccGeomPkg::*;

    localparam int codeW = $bits(adcCodeT);

    for (genvar j = 0; j < numCols; j++) begin : genCol
        logic [numLevels-1:0] slice;
        adcCodeT              count;

        assign slice = therm[j*numLevels +: numLevels];

        // Count the set levels instead of locating the top one
        // A bubble in a malformed code then costs one step, not a large jump
        always_comb begin
            count = '0;
            for (int k = 0; k < numLevels; k++) begin
                count = count + adcCodeT'(slice[k]);
            end
        end

        // All 16 levels set decodes to 16, which needs the fifth bit
        assign codes[j*codeW +: codeW] = count;
    end

endmodule

//--- src/qraccController.sv
// Command sequencer for the CIM array
// Drives precharge, wordline, write, sense and row-drive strobes and captures results
module qraccController #(
    parameter int macSettleCycles = 2
) (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   cmdValid,
    input  qraccCtrlPkg::opT       cmdOp,
    input  qraccGeomPkg::rowAddrT  cmdRow,
    input  qraccGeomPkg::colWordT  cmdData,
    input  qraccGeomPkg::rowVecT   cmdInput,
    input  qraccGeomPkg::colWordT  SA_OUT,
    input  qraccGeomPkg::macCodesT adcCodes,
    output qraccGeomPkg::rowVecT   WL,
    output logic                   PCH,
    output logic                   WRITE,
    output qraccGeomPkg::colWordT  WR_DATA,
    output logic                   SAEN,
    output qraccGeomPkg::rowVecT   VDR_SEL,
    output logic                   busy,
    output logic                   done,
    output qraccGeomPkg::colWordT  rdData,
    output qraccGeomPkg::macCodesT macCodes
);
    import qraccGeomPkg::*;
    import qraccCtrlPkg::*;

    // Evaluate cycle counter, sized so that macSettleCycles of 1 still gets one bit
    localparam int evalCntW = $clog2(macSettleCycles + 1);
    typedef logic [evalCntW-1:0] evalCntT;
    localparam evalCntT lastEval = evalCntT'(macSettleCycles - 1);

    ctrlStateT state;
    evalCntT   evalCnt;
    logic      accept;
    logic      evalLast;

    // Command fields held for the whole operation
    opT      opQ;
    rowAddrT rowQ;
    colWordT dataQ;
    rowVecT  inputQ;

    assign accept   = (state == sIdle) && cmdValid;
    assign evalLast = (state == sEval) && (evalCnt == lastEval);

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            state   <= sIdle;
            evalCnt <= '0;
        end else begin
            case (state)
                sIdle: begin
                    if (cmdValid) begin
                        evalCnt <= '0;
                        state   <= (cmdOp == opMac) ? sEval : sAccess;
                    end
                end
                sAccess: begin
                    state <= sDone;
                end
                sEval: begin
                    if (evalCnt == lastEval) begin
                        state <= sDone;
                    end else begin
                        evalCnt <= evalCnt + 1'b1;
                    end
                end
                sDone: begin
                    state <= sIdle;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            opQ    <= cmdOp;
            rowQ   <= cmdRow;
            dataQ  <= cmdData;
            inputQ <= cmdInput;
        end
    end

    // Read data lands at the end of the access cycle, MAC codes at the last settle edge
    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            rdData   <= '0;
            macCodes <= '0;
        end else begin
            if ((state == sAccess) && (opQ == opRead)) begin
                rdData <= SA_OUT;
            end
            if (evalLast) begin
                macCodes <= adcCodes;
            end
        end
    end

    // Strobes decode from the state, so they are quiet in sIdle and sDone
    assign PCH     = (state == sAccess);
    assign WL      = (state == sAccess) ? (rowVecT'(1) << rowQ) : '0;
    assign WRITE   = (state == sAccess) && (opQ == opWrite);
    assign SAEN    = (state == sAccess) && (opQ == opRead);
    assign WR_DATA = dataQ;
    assign VDR_SEL = (state == sEval) ? inputQ : '0;

    assign busy = (state != sIdle);
    assign done = (state == sDone);

endmodule

//--- src/qraccTop.sv
// Top level of the CIM column block
// Sequencer, bit-cell array and thermometer decoder
module qraccTop #(
    parameter int macSettleCycles = 2
) (
    input  logic                   CLK,
    input  logic                   rstN,
    input  logic                   cmdValid,
    input  qraccCtrlPkg::opT       cmdOp,
    input  qraccGeomPkg::rowAddrT  cmdRow,
    input  qraccGeomPkg::colWordT  cmdData,
    input  qraccGeomPkg::rowVecT   cmdInput,
    output logic                   busy,
    output logic                   done,
    output qraccGeomPkg::colWordT  rdData,
    output qraccGeomPkg::macCodesT macCodes
);
    import qraccGeomPkg::*;

    // Array strobes and data
    rowVecT   wordLine;
    logic     precharge;
    logic     writeEn;
    colWordT  wrData;
    logic     senseEn;
    rowVecT   vdrSel;
    colWordT  saOut;

    // Column ADC path
    thermT    adcOut;
    macCodesT adcCodes;

    qraccController #(
        .macSettleCycles(macSettleCycles)
    ) ctrl (
        .CLK     (CLK),
        .rstN    (rstN),
        .cmdValid(cmdValid),
        .cmdOp   (cmdOp),
        .cmdRow  (cmdRow),
        .cmdData (cmdData),
        .cmdInput(cmdInput),
        .SA_OUT  (saOut),
        .adcCodes(adcCodes),
        .WL      (wordLine),
        .PCH     (precharge),
        .WRITE   (writeEn),
        .WR_DATA (wrData),
        .SAEN    (senseEn),
        .VDR_SEL (vdrSel),
        .busy    (busy),
        .done    (done),
        .rdData  (rdData),
        .macCodes(macCodes)
    );

    qraccArray array (
        .CLK    (CLK),
        .WL     (wordLine),
        .PCH    (precharge),
        .WRITE  (writeEn),
        .WR_DATA(wrData),
        .SAEN   (senseEn),
        .VDR_SEL(vdrSel),
        .SA_OUT (saOut),
        .ADC_OUT(adcOut)
    );

    thermDecoder decoder (
        .therm(adcOut),
        .codes(adcCodes)
    );

endmodule

//--- bench/clockGen.sv
// Free-running testbench clock
module clockGen (
    output logic CLK
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period, starting low
    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

endmodule

//--- bench/qraccTop_asserts.sv
// Concurrent checks on the sequencer strobes, bound into qraccController
module qraccTop_asserts (
    input logic                    CLK,
    input logic                    rstN,
    input qraccCtrlPkg::ctrlStateT state,
    input qraccGeomPkg::rowVecT    WL,
    input logic                    PCH,
    input logic                    WRITE,
    input logic                    SAEN,
    input qraccGeomPkg::rowVecT    VDR_SEL,
    input logic                    done
);
    timeunit 1ns;
    timeprecision 100ps;
    import qraccCtrlPkg::*;

    doneOnePulse: assert property (@(posedge CLK) disable iff (!rstN) done |=> !done)
        else $error("done stayed high for more than one cycle");

    noWriteWithSense: assert property (@(posedge CLK) disable iff (!rstN) !(WRITE && SAEN))
        else $error("WRITE and SAEN high together");

    wordlineOneHot: assert property (@(posedge CLK) disable iff (!rstN) $onehot0(WL))
        else $error("more than one wordline raised");

    // Row drive belongs to the evaluate phase only
    driveOnlyInEval: assert property (@(posedge CLK) disable iff (!rstN)
        (state != sEval) |-> (VDR_SEL == '0))
        else $error("VDR_SEL driven outside sEval");

    quietWhenIdle: assert property (@(posedge CLK) disable iff (!rstN)
        (state == sIdle) |-> (!PCH && !WRITE && !SAEN && (WL == '0) && (VDR_SEL == '0)))
        else $error("array strobes active while idle");

endmodule

bind qraccController qraccTop_asserts ctrlAsserts (
    .CLK    (CLK),
    .rstN   (rstN),
    .state  (state),
    .WL     (WL),
    .PCH    (PCH),
    .WRITE  (WRITE),
    .SAEN   (SAEN),
    .VDR_SEL(VDR_SEL),
    .done   (done)
);

//--- bench/qraccTopTb.sv
// Directed tests for qraccTop with a shadow array model
// Timeout counter and pass/fail summary
module qraccTopTb;
    timeunit 1ns;
    timeprecision 100ps;
    import qraccGeomPkg::*;
    import qraccCtrlPkg::*;

    localparam int settle = 2;
    // About 200 commands of at most 5 cycles each, plus margin
    localparam int cycleLimit = 200 * 5 + 1000;

    logic     CLK, rstN, cmdValid, busy, done;
    opT       cmdOp;
    rowAddrT  cmdRow;
    colWordT  cmdData, rdData;
    rowVecT   cmdInput;
    macCodesT macCodes;

    colWordT shadow [numRows];
    int seed = 65;
    int errCount = 0;
    int passCount = 0;
    int failCount = 0;
    int cycles = 0;

    clockGen clkGen (.CLK(CLK));

    qraccTop #(.macSettleCycles(settle)) qraccTop_i (
        .CLK(CLK), .rstN(rstN), .cmdValid(cmdValid), .cmdOp(cmdOp), .cmdRow(cmdRow),
        .cmdData(cmdData), .cmdInput(cmdInput), .busy(busy), .done(done),
        .rdData(rdData), .macCodes(macCodes)
    );

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= cycleLimit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic expectEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errCount++;
        end
    endtask

    // Expected codes: per column count of rows with input and weight both 1, capped at 16
    function automatic macCodesT macExpect(input rowVecT vec);
        macCodesT codes;
        int cnt;
        codes = '0;
        for (int j = 0; j < numCols; j++) begin
            cnt = 0;
            for (int i = 0; i < numRows; i++) begin
                if (vec[i] && shadow[i][j]) begin
                    cnt++;
                end
            end
            codes[j*5 +: 5] = adcCodeT'((cnt > numLevels) ? numLevels : cnt);
        end
        return codes;
    endfunction

    function automatic rowVecT sparseVec();
        rowVecT vec;
        int nBits;
        vec = '0;
        nBits = $unsigned($random(seed)) % 11;
        repeat (nBits) begin
            vec[$unsigned($random(seed)) % numRows] = 1'b1;
        end
        return vec;
    endfunction

    task automatic sendCmd(input opT op, input rowAddrT row, input colWordT data,
                           input rowVecT vec);
        @(negedge CLK);
        // Sequencer must be back in idle before a new command
        expectEq(busy, 0, "busy before a command");
        cmdValid = 1'b1;
        cmdOp    = op;
        cmdRow   = row;
        cmdData  = data;
        cmdInput = vec;
        @(posedge CLK);
    endtask

    // Issue one command and count falling edges from acceptance until done
    task automatic runCmd(input opT op, input rowAddrT row, input colWordT data,
                          input rowVecT vec, input int expLat);
        int lat;
        sendCmd(op, row, data, vec);
        lat = 0;
        do begin
            @(negedge CLK);
            cmdValid = 1'b0;
            lat++;
            expectEq(busy, 1, "busy during a command");
        end while (!done && lat < 20);
        assert (done) else begin
            $display("Error at %0t: done never came after a command", $time);
            errCount++;
        end
        expectEq(lat, expLat, "cycles from acceptance to done");
        if (op == opWrite) begin
            shadow[row] = data;
        end
    endtask

    task automatic finishTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic testReset();
        int errsBefore;
        errsBefore = errCount;
        expectEq(busy, 0, "busy after reset");
        expectEq(done, 0, "done after reset");
        expectEq(rdData, 0, "rdData after reset");
        expectEq(macCodes, 0, "macCodes after reset");
        finishTest("reset", errsBefore);
    endtask

    task automatic testMacSaturation();
        int errsBefore;
        errsBefore = errCount;
        for (int i = 0; i < numRows; i++) begin
            runCmd(opWrite, rowAddrT'(i), 8'hFF, '0, 2);
        end
        runCmd(opMac, '0, '0, '1, 1 + settle);
        for (int j = 0; j < numCols; j++) begin
            expectEq(macCodes[j*5 +: 5], 16, "saturated column code");
        end
        runCmd(opMac, '0, '0, '0, 1 + settle);
        expectEq(macCodes, 0, "codes for zero input");
        finishTest("mac saturation", errsBefore);
    endtask

    task automatic testWriteRead();
        int errsBefore;
        rowAddrT rows [20];
        errsBefore = errCount;
        for (int n = 0; n < 20; n++) begin
            rows[n] = rowAddrT'($random(seed));
            runCmd(opWrite, rows[n], colWordT'($random(seed)), '0, 2);
        end
        for (int n = 0; n < 20; n++) begin
            runCmd(opRead, rows[n], '0, '0, 2);
            expectEq(rdData, shadow[rows[n]], "read data");
        end
        finishTest("write then read", errsBefore);
    endtask

    task automatic testMacSparse();
        int errsBefore;
        rowVecT vec;
        errsBefore = errCount;
        repeat (4) begin
            vec = sparseVec();
            runCmd(opMac, '0, '0, vec, 1 + settle);
            expectEq(macCodes, macExpect(vec), "sparse MAC codes");
        end
        finishTest("mac sparse", errsBefore);
    endtask

    task automatic testBusyIgnore();
        int errsBefore;
        rowAddrT r, r2;
        colWordT oldVal;
        errsBefore = errCount;
        r = rowAddrT'($random(seed));
        r2 = r + 1'b1;
        oldVal = shadow[r2];
        sendCmd(opRead, r, '0, '0);
        // Second write arrives while the read is still in its access cycle
        @(negedge CLK);
        cmdOp   = opWrite;
        cmdRow  = r2;
        cmdData = ~oldVal;
        @(negedge CLK);
        cmdValid = 1'b0;
        assert (done) else begin
            $display("Error at %0t: read did not finish two cycles after acceptance", $time);
            errCount++;
        end
        expectEq(rdData, shadow[r], "read data with a write pulsed while busy");
        runCmd(opRead, r2, '0, '0, 2);
        expectEq(rdData, oldVal, "row of the ignored write");
        finishTest("ignored while busy", errsBefore);
    endtask

    task automatic testResultHold();
        int errsBefore;
        rowAddrT rdRow;
        colWordT expRd;
        macCodesT expMac;
        errsBefore = errCount;
        rdRow = rowAddrT'($random(seed));
        expRd = shadow[rdRow];
        runCmd(opRead, rdRow, '0, '0, 2);
        expectEq(rdData, expRd, "read data before the hold check");
        // Full input keeps the codes well away from zero
        expMac = macExpect('1);
        runCmd(opMac, '0, '0, '1, 1 + settle);
        expectEq(macCodes, expMac, "MAC codes before the hold check");
        // Overwrite the row that was just read with different data
        runCmd(opWrite, rdRow, ~expRd, '0, 2);
        expectEq(rdData, expRd, "rdData across a write");
        expectEq(macCodes, expMac, "macCodes across a write");
        finishTest("result hold", errsBefore);
    endtask

    initial begin
        rstN = 1'b0;
        cmdValid = 1'b0;
        cmdOp = opWrite;
        cmdRow = '0;
        cmdData = '0;
        cmdInput = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rstN = 1'b1;
        testReset();
        // Saturation fill runs first so that every row holds a known value
        testMacSaturation();
        testWriteRead();
        testMacSparse();
        testBusyIgnore();
        testResultHold();
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- qraccTop.f
src/qraccGeomPkg.sv
src/qraccCtrlPkg.sv
src/qraccArray.sv
src/thermDecoder.sv
src/qraccController.sv
src/qraccTop.sv
bench/clockGen.sv
bench/qraccTop_asserts.sv
bench/qraccTopTb.sv

//--- Makefile
# Verilator build and run of the qraccTop testbench
VERILATOR ?= verilator
TOP       ?= qraccTopTb
FILELIST  ?= qraccTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
